// ==== rtl/bedrock_mem_pkg.sv ====
package bedrock_mem_pkg;

  // ----------------------------------------------------------------------
  // Memory message geometry
  // ----------------------------------------------------------------------

  localparam int mem_addr_width_lp = 16;
  localparam int mem_data_width_lp = 32;
  localparam int mem_tag_width_lp  = 4;

  typedef enum logic [0:0] {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // ----------------------------------------------------------------------
  // Command and response message
  // ----------------------------------------------------------------------

  // The tag is the requester id and comes back unchanged in the response
  typedef struct packed {
    mem_op_e                      opcode;
    logic [mem_addr_width_lp-1:0] addr;
    logic [mem_data_width_lp-1:0] data;
    logic [mem_tag_width_lp-1:0]  tag;
  } mem_msg_s;

endpackage

// ==== rtl/l2_pkg.sv ====
package l2_pkg;

  // ----------------------------------------------------------------------
  // Cache geometry
  // ----------------------------------------------------------------------

  localparam int addr_width_lp        = 16;
  localparam int word_width_lp        = 32;
  localparam int block_words_lp       = 4;
  localparam int sets_lp              = 8;

  localparam int index_width_lp       = $clog2(sets_lp);
  localparam int offset_width_lp      = $clog2(block_words_lp);
  localparam int byte_offset_width_lp = $clog2(word_width_lp / 8);
  localparam int tag_width_lp         = addr_width_lp - index_width_lp
                                        - offset_width_lp - byte_offset_width_lp;

  // Bit positions of the address fields
  localparam int word_lsb_lp          = byte_offset_width_lp;
  localparam int index_lsb_lp         = word_lsb_lp + offset_width_lp;
  localparam int tag_lsb_lp           = index_lsb_lp + index_width_lp;

  localparam int data_addr_width_lp   = index_width_lp + offset_width_lp;
  localparam int data_words_lp        = sets_lp * block_words_lp;

  // ----------------------------------------------------------------------
  // Cache and DMA types
  // ----------------------------------------------------------------------

  typedef enum logic [0:0] {
    e_ld_w = 1'b0,
    e_st_w = 1'b1
  } cache_op_e;

  typedef struct packed {
    cache_op_e                opcode;
    logic [addr_width_lp-1:0] addr;
    logic [word_width_lp-1:0] data;
  } cache_pkt_s;

  // Address is always block aligned
  typedef struct packed {
    logic                     write_not_read;
    logic [addr_width_lp-1:0] addr;
  } dma_pkt_s;

  typedef struct packed {
    logic                    valid;
    logic                    dirty;
    logic [tag_width_lp-1:0] tag;
  } tag_entry_s;

  typedef enum logic [2:0] {
    e_idle,
    e_lookup,
    e_evict_req,
    e_evict_data,
    e_fill_req,
    e_fill_data,
    e_reply
  } l2_state_e;

endpackage

// ==== rtl/mem_to_cache.sv ====
`timescale 1ns/1ps

module mem_to_cache
  (input                                      clk_i
   , input                                    rst_n_i

   , input  bedrock_mem_pkg::mem_msg_s        mem_cmd_i
   , input                                    mem_cmd_v_i
   , output logic                             mem_cmd_ready_and_o

   , output bedrock_mem_pkg::mem_msg_s        mem_resp_o
   , output logic                             mem_resp_v_o
   , input                                    mem_resp_yumi_i

   , output l2_pkg::cache_pkt_s               cache_pkt_o
   , output logic                             cache_pkt_v_o
   , input                                    cache_pkt_ready_i

   , input  [l2_pkg::word_width_lp-1:0]       cache_data_i
   , input                                    cache_data_v_i
   , output logic                             cache_data_yumi_o
   );

  // The held command becomes the response once the reply arrives
  bedrock_mem_pkg::mem_msg_s msg_r;
  logic full_r, sent_r, resp_v_r;

  assign mem_cmd_ready_and_o = ~full_r;
  assign cache_pkt_v_o       = full_r & ~sent_r;
  assign cache_data_yumi_o   = cache_data_v_i & sent_r & ~resp_v_r;
  assign mem_resp_v_o        = resp_v_r;
  assign mem_resp_o          = msg_r;

  always_comb begin
    if (msg_r.opcode == bedrock_mem_pkg::e_mem_wr)
      cache_pkt_o.opcode = l2_pkg::e_st_w;
    else
      cache_pkt_o.opcode = l2_pkg::e_ld_w;
    cache_pkt_o.addr = msg_r.addr;
    cache_pkt_o.data = msg_r.data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_r   <= 1'b0;
      sent_r   <= 1'b0;
      resp_v_r <= 1'b0;
    end else begin
      if (mem_cmd_v_i && mem_cmd_ready_and_o)
        full_r <= 1'b1;
      if (cache_pkt_v_o && cache_pkt_ready_i)
        sent_r <= 1'b1;
      if (cache_data_yumi_o)
        resp_v_r <= 1'b1;
      if (mem_resp_v_o && mem_resp_yumi_i) begin
        full_r   <= 1'b0;
        sent_r   <= 1'b0;
        resp_v_r <= 1'b0;
      end
    end
  end

  // A write keeps its own data as the response payload
  always_ff @(posedge clk_i) begin
    if (mem_cmd_v_i && mem_cmd_ready_and_o)
      msg_r <= mem_cmd_i;
    else if (cache_data_yumi_o && (msg_r.opcode == bedrock_mem_pkg::e_mem_rd))
      msg_r.data <= cache_data_i;
  end

endmodule

// ==== rtl/l2_tag_array.sv ====
`timescale 1ns/1ps

module l2_tag_array
  (input                                       clk_i
   , input                                     rst_n_i
   , input  [l2_pkg::index_width_lp-1:0]       idx_i
   , input                                     we_i
   , input  l2_pkg::tag_entry_s                wdata_i
   , output l2_pkg::tag_entry_s                rdata_o
   );

  logic [l2_pkg::sets_lp-1:0]      valid_r;
  logic [l2_pkg::sets_lp-1:0]      dirty_r;
  logic [l2_pkg::tag_width_lp-1:0] tag_r [l2_pkg::sets_lp];

  logic                            rd_valid_r;
  logic                            rd_dirty_r;
  logic [l2_pkg::tag_width_lp-1:0] rd_tag_r;

  assign rdata_o = '{valid: rd_valid_r, dirty: rd_dirty_r, tag: rd_tag_r};

  // The read is write-first so a lookup right after a fill sees the new entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_r    <= '0;
      rd_valid_r <= 1'b0;
    end else begin
      if (we_i)
        valid_r[idx_i] <= wdata_i.valid;
      rd_valid_r <= we_i ? wdata_i.valid : valid_r[idx_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      dirty_r[idx_i] <= wdata_i.dirty;
      tag_r[idx_i]   <= wdata_i.tag;
    end
    rd_dirty_r <= we_i ? wdata_i.dirty : dirty_r[idx_i];
    rd_tag_r   <= we_i ? wdata_i.tag : tag_r[idx_i];
  end

endmodule

// ==== rtl/l2_data_array.sv ====
`timescale 1ns/1ps

module l2_data_array
  (input                                         clk_i
   , input  [l2_pkg::data_addr_width_lp-1:0]     addr_i
   , input                                       we_i
   , input  [l2_pkg::word_width_lp-1:0]          wdata_i
   , output logic [l2_pkg::word_width_lp-1:0]    rdata_o
   );

  logic [l2_pkg::word_width_lp-1:0] mem_r [l2_pkg::data_words_lp];

  // The single port read returns the word held before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (we_i)
      mem_r[addr_i] <= wdata_i;
    rdata_o <= mem_r[addr_i];
  end

endmodule

// ==== rtl/l2_ctrl.sv ====
`timescale 1ns/1ps

module l2_ctrl
  (input                                           clk_i
   , input                                         rst_n_i

   , input  l2_pkg::cache_pkt_s                    cache_pkt_i
   , input                                         cache_pkt_v_i
   , output logic                                  cache_pkt_ready_o

   , output logic [l2_pkg::word_width_lp-1:0]      cache_data_o
   , output logic                                  cache_data_v_o
   , input                                         cache_data_yumi_i

   , output logic [l2_pkg::index_width_lp-1:0]     tag_idx_o
   , output logic                                  tag_we_o
   , output l2_pkg::tag_entry_s                    tag_wdata_o
   , input  l2_pkg::tag_entry_s                    tag_rdata_i

   , output logic [l2_pkg::data_addr_width_lp-1:0] data_addr_o
   , output logic                                  data_we_o
   , output logic [l2_pkg::word_width_lp-1:0]      data_wdata_o
   , input  [l2_pkg::word_width_lp-1:0]            data_rdata_i

   , output l2_pkg::dma_pkt_s                      dma_pkt_o
   , output logic                                  dma_pkt_v_o
   , input                                         dma_pkt_yumi_i

   , input  [l2_pkg::word_width_lp-1:0]            dma_data_i
   , input                                         dma_data_v_i
   , output logic                                  dma_data_ready_and_o

   , output logic [l2_pkg::word_width_lp-1:0]      dma_data_o
   , output logic                                  dma_data_v_o
   , input                                         dma_data_yumi_i
   );

  l2_pkg::l2_state_e state_r, state_n;
  l2_pkg::cache_pkt_s pkt_r;
  logic [l2_pkg::offset_width_lp-1:0] beat_r, beat_n;

  logic [l2_pkg::tag_width_lp-1:0]    pkt_tag;
  logic [l2_pkg::index_width_lp-1:0]  pkt_idx, in_idx;
  logic [l2_pkg::offset_width_lp-1:0] pkt_word;
  logic hit, last_beat;

  assign pkt_tag  = pkt_r.addr[l2_pkg::tag_lsb_lp +: l2_pkg::tag_width_lp];
  assign pkt_idx  = pkt_r.addr[l2_pkg::index_lsb_lp +: l2_pkg::index_width_lp];
  assign pkt_word = pkt_r.addr[l2_pkg::word_lsb_lp +: l2_pkg::offset_width_lp];
  assign in_idx   = cache_pkt_i.addr[l2_pkg::index_lsb_lp +: l2_pkg::index_width_lp];

  assign hit       = tag_rdata_i.valid && (tag_rdata_i.tag == pkt_tag);
  assign last_beat = &beat_r;

  // Both the reply and the eviction stream come straight off the data array
  assign cache_pkt_ready_o    = (state_r == l2_pkg::e_idle);
  assign cache_data_v_o       = (state_r == l2_pkg::e_reply);
  assign cache_data_o         = data_rdata_i;
  assign dma_data_v_o         = (state_r == l2_pkg::e_evict_data);
  assign dma_data_o           = data_rdata_i;
  assign dma_data_ready_and_o = (state_r == l2_pkg::e_fill_data);
  assign dma_pkt_v_o          = (state_r == l2_pkg::e_evict_req)
                                || (state_r == l2_pkg::e_fill_req);

  always_comb begin
    dma_pkt_o.write_not_read = (state_r == l2_pkg::e_evict_req);
    if (state_r == l2_pkg::e_evict_req)
      dma_pkt_o.addr = {tag_rdata_i.tag, pkt_idx, {l2_pkg::index_lsb_lp{1'b0}}};
    else
      dma_pkt_o.addr = {pkt_tag, pkt_idx, {l2_pkg::index_lsb_lp{1'b0}}};
  end

  // ----------------------------------------------------------------------
  // Next state and array control
  // ----------------------------------------------------------------------

  always_comb begin
    state_n      = state_r;
    beat_n       = beat_r;
    tag_idx_o    = pkt_idx;
    tag_we_o     = 1'b0;
    tag_wdata_o  = '{valid: 1'b1, dirty: 1'b0, tag: pkt_tag};
    data_addr_o  = {pkt_idx, pkt_word};
    data_we_o    = 1'b0;
    data_wdata_o = pkt_r.data;

    case (state_r)
      l2_pkg::e_idle: begin
        // Present the incoming index so the lookup sees its tag entry next cycle
        tag_idx_o = in_idx;
        if (cache_pkt_v_i)
          state_n = l2_pkg::e_lookup;
      end
      l2_pkg::e_lookup: begin
        if (hit) begin
          state_n = l2_pkg::e_reply;
          if (pkt_r.opcode == l2_pkg::e_st_w) begin
            data_we_o         = 1'b1;
            tag_we_o          = 1'b1;
            tag_wdata_o.dirty = 1'b1;
          end
        end else if (tag_rdata_i.valid && tag_rdata_i.dirty) begin
          state_n = l2_pkg::e_evict_req;
        end else begin
          state_n = l2_pkg::e_fill_req;
        end
      end
      l2_pkg::e_evict_req: begin
        data_addr_o = {pkt_idx, beat_r};
        if (dma_pkt_yumi_i)
          state_n = l2_pkg::e_evict_data;
      end
      l2_pkg::e_evict_data: begin
        if (dma_data_yumi_i) begin
          beat_n = beat_r + 1'b1;
          if (last_beat)
            state_n = l2_pkg::e_fill_req;
        end
        // Read ahead so the next word is ready the cycle after a yumi
        data_addr_o = {pkt_idx, beat_n};
      end
      l2_pkg::e_fill_req: begin
        if (dma_pkt_yumi_i)
          state_n = l2_pkg::e_fill_data;
      end
      l2_pkg::e_fill_data: begin
        data_addr_o  = {pkt_idx, beat_r};
        data_wdata_o = dma_data_i;
        if (dma_data_v_i) begin
          data_we_o = 1'b1;
          beat_n    = beat_r + 1'b1;
          if (last_beat) begin
            tag_we_o = 1'b1;
            state_n  = l2_pkg::e_lookup;
          end
        end
      end
      l2_pkg::e_reply: begin
        if (cache_data_yumi_i)
          state_n = l2_pkg::e_idle;
      end
      default: state_n = l2_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= l2_pkg::e_idle;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      beat_r  <= beat_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_pkt_v_i && cache_pkt_ready_o)
      pkt_r <= cache_pkt_i;
  end

endmodule

// ==== rtl/l2_mem_top.sv ====
`timescale 1ns/1ps

module l2_mem_top
  (input                                       clk_i
   , input                                     rst_n_i

   , input  bedrock_mem_pkg::mem_msg_s         mem_cmd_i
   , input                                     mem_cmd_v_i
   , output logic                              mem_cmd_ready_and_o

   , output bedrock_mem_pkg::mem_msg_s         mem_resp_o
   , output logic                              mem_resp_v_o
   , input                                     mem_resp_yumi_i

   , output l2_pkg::dma_pkt_s                  dma_pkt_o
   , output logic                              dma_pkt_v_o
   , input                                     dma_pkt_yumi_i

   , input  [l2_pkg::word_width_lp-1:0]        dma_data_i
   , input                                     dma_data_v_i
   , output logic                              dma_data_ready_and_o

   , output logic [l2_pkg::word_width_lp-1:0]  dma_data_o
   , output logic                              dma_data_v_o
   , input                                     dma_data_yumi_i
   );

  // ----------------------------------------------------------------------
  // Bridge to cache controller
  // ----------------------------------------------------------------------

  l2_pkg::cache_pkt_s cache_pkt;
  logic cache_pkt_v, cache_pkt_ready;
  logic [l2_pkg::word_width_lp-1:0] cache_data;
  logic cache_data_v, cache_data_yumi;

  mem_to_cache
   mem_to_cache
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)

     ,.mem_cmd_i(mem_cmd_i)
     ,.mem_cmd_v_i(mem_cmd_v_i)
     ,.mem_cmd_ready_and_o(mem_cmd_ready_and_o)

     ,.mem_resp_o(mem_resp_o)
     ,.mem_resp_v_o(mem_resp_v_o)
     ,.mem_resp_yumi_i(mem_resp_yumi_i)

     ,.cache_pkt_o(cache_pkt)
     ,.cache_pkt_v_o(cache_pkt_v)
     ,.cache_pkt_ready_i(cache_pkt_ready)

     ,.cache_data_i(cache_data)
     ,.cache_data_v_i(cache_data_v)
     ,.cache_data_yumi_o(cache_data_yumi)
     );

  // ----------------------------------------------------------------------
  // Controller and arrays
  // ----------------------------------------------------------------------

  logic [l2_pkg::index_width_lp-1:0] tag_idx;
  logic tag_we;
  l2_pkg::tag_entry_s tag_wdata, tag_rdata;

  logic [l2_pkg::data_addr_width_lp-1:0] data_addr;
  logic data_we;
  logic [l2_pkg::word_width_lp-1:0] data_wdata, data_rdata;

  l2_ctrl
   ctrl
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)

     ,.cache_pkt_i(cache_pkt)
     ,.cache_pkt_v_i(cache_pkt_v)
     ,.cache_pkt_ready_o(cache_pkt_ready)

     ,.cache_data_o(cache_data)
     ,.cache_data_v_o(cache_data_v)
     ,.cache_data_yumi_i(cache_data_yumi)

     ,.tag_idx_o(tag_idx)
     ,.tag_we_o(tag_we)
     ,.tag_wdata_o(tag_wdata)
     ,.tag_rdata_i(tag_rdata)

     ,.data_addr_o(data_addr)
     ,.data_we_o(data_we)
     ,.data_wdata_o(data_wdata)
     ,.data_rdata_i(data_rdata)

     ,.dma_pkt_o(dma_pkt_o)
     ,.dma_pkt_v_o(dma_pkt_v_o)
     ,.dma_pkt_yumi_i(dma_pkt_yumi_i)

     ,.dma_data_i(dma_data_i)
     ,.dma_data_v_i(dma_data_v_i)
     ,.dma_data_ready_and_o(dma_data_ready_and_o)

     ,.dma_data_o(dma_data_o)
     ,.dma_data_v_o(dma_data_v_o)
     ,.dma_data_yumi_i(dma_data_yumi_i)
     );

  l2_tag_array
   tag_array
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.idx_i(tag_idx)
     ,.we_i(tag_we)
     ,.wdata_i(tag_wdata)
     ,.rdata_o(tag_rdata)
     );

  l2_data_array
   data_array
    (.clk_i(clk_i)
     ,.addr_i(data_addr)
     ,.we_i(data_we)
     ,.wdata_i(data_wdata)
     ,.rdata_o(data_rdata)
     );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
  (output logic clk_o
   );

  // Free running clock with a 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  localparam int wait_limit_lp = 400;

  logic clk, rst_n;
  bedrock_mem_pkg::mem_msg_s mem_cmd, mem_resp;
  logic mem_cmd_v, mem_cmd_ready_and, mem_resp_v, mem_resp_yumi;
  l2_pkg::dma_pkt_s dma_pkt;
  logic dma_pkt_v, dma_pkt_yumi;
  logic [31:0] dma_data_in, dma_data_out;
  logic dma_data_in_v, dma_data_in_ready, dma_data_out_v, dma_data_out_yumi;

  // DRAM contents and the reference copy that sees every write
  logic [31:0] dram [16384];
  logic [31:0] ref_mem [16384];
  l2_pkg::dma_pkt_s dma_log [$];
  int err_count, evict_beats, tests_run, tests_failed;

  tb_clock clock (.clk_o(clk));

  l2_mem_top dut
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.mem_cmd_i(mem_cmd)
     ,.mem_cmd_v_i(mem_cmd_v)
     ,.mem_cmd_ready_and_o(mem_cmd_ready_and)
     ,.mem_resp_o(mem_resp)
     ,.mem_resp_v_o(mem_resp_v)
     ,.mem_resp_yumi_i(mem_resp_yumi)
     ,.dma_pkt_o(dma_pkt)
     ,.dma_pkt_v_o(dma_pkt_v)
     ,.dma_pkt_yumi_i(dma_pkt_yumi)
     ,.dma_data_i(dma_data_in)
     ,.dma_data_v_i(dma_data_in_v)
     ,.dma_data_ready_and_o(dma_data_in_ready)
     ,.dma_data_o(dma_data_out)
     ,.dma_data_v_o(dma_data_out_v)
     ,.dma_data_yumi_i(dma_data_out_yumi)
     );

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic check_msg(string name, bedrock_mem_pkg::mem_msg_s got,
                           bedrock_mem_pkg::mem_msg_s exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_dma_pkt(string name, l2_pkg::dma_pkt_s got, l2_pkg::dma_pkt_s exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    err_count++;
    $display("Gave up at t=%0t after waiting too long for %s", $time, what);
  endtask

  function automatic l2_pkg::dma_pkt_s make_dma(logic write_not_read, logic [15:0] addr);
    l2_pkg::dma_pkt_s pkt;
    pkt.write_not_read = write_not_read;
    pkt.addr = addr;
    return pkt;
  endfunction

  // ----------------------------------------------------------------------
  // DRAM model
  // ----------------------------------------------------------------------

  task automatic take_evict(logic [15:0] base);
    logic [13:0] widx;
    int n;
    widx = base[15:2];
    repeat (l2_pkg::block_words_lp) begin
      repeat ($urandom_range(0, 2)) @(posedge clk);
      n = 0;
      @(negedge clk);
      while (!dma_data_out_v && n < wait_limit_lp) begin
        @(negedge clk);
        n++;
      end
      if (!dma_data_out_v) begin
        report_timeout("dma_data_v_o");
        return;
      end
      // The cache holds the newest copy, so it must match the reference
      check_word("dma_data_o", dma_data_out, ref_mem[widx]);
      dram[widx] = dma_data_out;
      evict_beats++;
      @(posedge clk);
      dma_data_out_yumi <= 1'b1;
      @(posedge clk);
      dma_data_out_yumi <= 1'b0;
      widx++;
    end
  endtask

  task automatic give_fill(logic [15:0] base);
    logic [13:0] widx;
    logic stuck;
    int n;
    widx = base[15:2];
    repeat (l2_pkg::block_words_lp) begin
      repeat ($urandom_range(0, 2)) @(posedge clk);
      @(posedge clk);
      dma_data_in   <= dram[widx];
      dma_data_in_v <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!dma_data_in_ready && n < wait_limit_lp) begin
        @(negedge clk);
        n++;
      end
      stuck = !dma_data_in_ready;
      @(posedge clk);
      dma_data_in_v <= 1'b0;
      if (stuck) begin
        report_timeout("dma_data_ready_and_o");
        return;
      end
      widx++;
    end
  endtask

  task automatic serve_dma();
    l2_pkg::dma_pkt_s pkt;
    pkt = dma_pkt;
    dma_log.push_back(pkt);
    repeat ($urandom_range(0, 3)) @(posedge clk);
    @(posedge clk);
    dma_pkt_yumi <= 1'b1;
    @(posedge clk);
    dma_pkt_yumi <= 1'b0;
    if (pkt.write_not_read)
      take_evict(pkt.addr);
    else
      give_fill(pkt.addr);
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && dma_pkt_v)
        serve_dma();
    end
  end

  // ----------------------------------------------------------------------
  // Requester side
  // ----------------------------------------------------------------------

  task automatic run_cmd(bedrock_mem_pkg::mem_op_e op, logic [15:0] addr,
                         logic [31:0] data, logic [3:0] tag, int hold);
    bedrock_mem_pkg::mem_msg_s cmd, exp, first;
    int n;
    cmd.opcode = op;
    cmd.addr   = addr;
    cmd.data   = data;
    cmd.tag    = tag;
    exp = cmd;
    if (op == bedrock_mem_pkg::e_mem_rd)
      exp.data = ref_mem[addr[15:2]];
    else
      ref_mem[addr[15:2]] = data;
    n = 0;
    @(negedge clk);
    while (!mem_cmd_ready_and && n < wait_limit_lp) begin
      @(negedge clk);
      n++;
    end
    if (!mem_cmd_ready_and) begin
      report_timeout("mem_cmd_ready_and_o");
      return;
    end
    @(posedge clk);
    mem_cmd   <= cmd;
    mem_cmd_v <= 1'b1;
    @(posedge clk);
    mem_cmd_v <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!mem_resp_v && n < wait_limit_lp) begin
      @(negedge clk);
      n++;
    end
    if (!mem_resp_v) begin
      report_timeout("mem_resp_v_o");
      return;
    end
    first = mem_resp;
    check_msg("mem_resp_o", first, exp);
    // While yumi is held off the response must sit still and block new commands
    repeat (hold) begin
      @(negedge clk);
      check_bit("mem_resp_v_o", mem_resp_v, 1'b1);
      check_msg("mem_resp_o", mem_resp, first);
      check_bit("mem_cmd_ready_and_o", mem_cmd_ready_and, 1'b0);
    end
    @(posedge clk);
    mem_resp_yumi <= 1'b1;
    @(posedge clk);
    mem_resp_yumi <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------

  task automatic finish_test(string name, int start);
    tests_run++;
    if (err_count == start) begin
      $display("%-22s ok", name);
    end else begin
      tests_failed++;
      $display("%-22s FAILED with %0d errors", name, err_count - start);
    end
  endtask

  task automatic check_idle_outputs();
    check_bit("mem_resp_v_o", mem_resp_v, 1'b0);
    check_bit("dma_pkt_v_o", dma_pkt_v, 1'b0);
    check_bit("dma_data_v_o", dma_data_out_v, 1'b0);
    check_bit("dma_data_ready_and_o", dma_data_in_ready, 1'b0);
    check_bit("mem_cmd_ready_and_o", mem_cmd_ready_and, 1'b1);
  endtask

  task automatic test_reset();
    int start;
    start = err_count;
    repeat (5) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle_outputs();
    finish_test("reset", start);
  endtask

  task automatic test_read_miss();
    int start;
    start = err_count;
    dma_log.delete();
    run_cmd(bedrock_mem_pkg::e_mem_rd, 16'h0128, 32'h0, 4'h3, 0);
    if (dma_log.size() != 1)
      report_dma_count(1);
    else
      check_dma_pkt("dma_pkt_o", dma_log[0], make_dma(1'b0, 16'h0120));
    finish_test("read_miss_fill", start);
  endtask

  task automatic report_dma_count(int expected);
    err_count++;
    $display("Expected %0d DMA packets but the cache issued %0d", expected, dma_log.size());
  endtask

  task automatic test_write_read();
    int start;
    start = err_count;
    run_cmd(bedrock_mem_pkg::e_mem_wr, 16'h0364, 32'hcafe_0001, 4'h5, 0);
    dma_log.delete();
    run_cmd(bedrock_mem_pkg::e_mem_rd, 16'h0364, 32'h0, 4'h6, 0);
    if (dma_log.size() != 0)
      report_dma_count(0);
    finish_test("write_then_read_hit", start);
  endtask

  task automatic test_dirty_evict();
    int start, beats;
    start = err_count;
    run_cmd(bedrock_mem_pkg::e_mem_wr, 16'h0248, 32'h5a5a_0001, 4'h1, 0);
    dma_log.delete();
    beats = evict_beats;
    // Same index with the next tag up
    run_cmd(bedrock_mem_pkg::e_mem_rd, 16'h02c4, 32'h0, 4'h2, 0);
    if (dma_log.size() != 2) begin
      report_dma_count(2);
    end else begin
      check_dma_pkt("dma_pkt_o", dma_log[0], make_dma(1'b1, 16'h0240));
      check_dma_pkt("dma_pkt_o", dma_log[1], make_dma(1'b0, 16'h02c0));
    end
    if (evict_beats - beats != 4) begin
      err_count++;
      $display("Expected 4 eviction words but saw %0d", evict_beats - beats);
    end
    finish_test("dirty_eviction", start);
  endtask

  task automatic test_backpressure();
    int start;
    start = err_count;
    run_cmd(bedrock_mem_pkg::e_mem_rd, 16'h0128, 32'h0, 4'h9, 6);
    finish_test("response_backpressure", start);
  endtask

  task automatic test_random();
    int start;
    logic [7:0] widx;
    bedrock_mem_pkg::mem_op_e op;
    start = err_count;
    repeat (200) begin
      op   = $urandom_range(0, 1) ? bedrock_mem_pkg::e_mem_wr : bedrock_mem_pkg::e_mem_rd;
      widx = 8'($urandom_range(0, 255));
      run_cmd(op, {6'd0, widx, 2'b00}, $urandom, 4'($urandom_range(0, 15)),
              int'($urandom_range(0, 2)));
    end
    finish_test("random_traffic", start);
  endtask

  initial begin
    logic [13:0] widx;
    void'($urandom(76265));
    rst_n             = 1'b0;
    mem_cmd           = '0;
    mem_cmd_v         = 1'b0;
    mem_resp_yumi     = 1'b0;
    dma_pkt_yumi      = 1'b0;
    dma_data_in       = '0;
    dma_data_in_v     = 1'b0;
    dma_data_out_yumi = 1'b0;
    err_count         = 0;
    evict_beats       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    widx = '0;
    repeat (16384) begin
      dram[widx]    = $urandom;
      ref_mem[widx] = dram[widx];
      widx++;
    end

    test_reset();
    test_read_miss();
    test_write_read();
    test_dirty_evict();
    test_backpressure();
    test_random();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/bedrock_mem_pkg.sv
rtl/l2_pkg.sv
rtl/mem_to_cache.sv
rtl/l2_tag_array.sv
rtl/l2_data_array.sv
rtl/l2_ctrl.sv
rtl/l2_mem_top.sv
bench/tb_clock.sv
bench/tb_top.sv

// ==== Makefile ====
SIM  = obj_dir/tb_top
SRCS = $(shell cat list.f)

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f list.f --top-module tb_top --Mdir obj_dir -o tb_top

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
